// File: hw/bpu_settings.svh
/*
  Sizing for the branch prediction unit.
  Addresses are word aligned, so the index starts at PC bit 2.
  BPU_BANKS must stay equal to 2**BPU_HIST_BITS, one bank per history value.
  BPU_TAG_BITS and BPU_ENTRIES are derived and should not be edited alone.
*/
`ifndef BPU_SETTINGS_SVH
`define BPU_SETTINGS_SVH

// instruction address width
`define BPU_PC_BITS 32

// pc bits used to index a bank, taken from bit 2 upward
`define BPU_INDEX_BITS 6

// entries per bank
`define BPU_ENTRIES (1 << `BPU_INDEX_BITS)

// remaining upper pc bits form the tag
`define BPU_TAG_BITS (`BPU_PC_BITS - `BPU_INDEX_BITS - 2)

// global history of conditional outcomes
`define BPU_HIST_BITS 2

// one bank for every history pattern
`define BPU_BANKS (1 << `BPU_HIST_BITS)

`endif

// File: hw/bpuPkg.sv
/*
  Types shared by the prediction unit.
  Widths follow the sizing macros; change those, not the typedefs.
  Branch type codes are the ones the execute stage reports on resolve.
  counterT is the per-entry 2-bit saturating counter.
*/
`include "bpu_settings.svh"

package bpuPkg;

    // instruction address
    typedef logic [`BPU_PC_BITS-1:0] addrT;

    // bank row select
    typedef logic [`BPU_INDEX_BITS-1:0] indexT;

    // pc bits above the index
    typedef logic [`BPU_TAG_BITS-1:0] tagT;

    // bit 0 holds the newest outcome
    typedef logic [`BPU_HIST_BITS-1:0] histT;

    // branch type as reported by decode / execute
    typedef logic [1:0] brTypeT;

    // not a branch, or nothing learned yet
    localparam brTypeT BR_NONE = 2'd0;
    // conditional, direction from the counter
    localparam brTypeT BR_IMME = 2'd1;
    // call, always taken
    localparam brTypeT BR_CALL = 2'd2;
    // return, always taken to the stored target
    localparam brTypeT BR_RETN = 2'd3;

    // saturating counter, high bit means predict taken
    typedef enum logic [1:0] {
        sNotTaken = 2'd0,
        wNotTaken = 2'd1,
        wTaken    = 2'd2,
        sTaken    = 2'd3
    } counterT;

endpackage

// File: hw/bhtUpdate.sv
/*
  Resolve-side write path of the predictor.
  One resolve per cycle at most; there is no queue or back-pressure.
  resolveHit, resolveCount and resolveHistory must be the values the
  predictor gave for this branch, or the wrong bank and counter get written.
  The history only moves on resolved conditional branches.
*/
`timescale 1ns/1ps
`include "bpu_settings.svh"

module bhtUpdate import bpuPkg::*; (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   resolveValid,
    input  addrT                   resolvePc,
    input  addrT                   resolveTarget,
    input  brTypeT                 resolveType,
    input  logic                   resolveTaken,
    input  logic                   resolveHit,
    input  counterT                resolveCount,
    input  histT                   resolveHistory,
    output logic [`BPU_BANKS-1:0]  bankWe,
    output indexT                  wrIndex,
    output tagT                    wrTag,
    output addrT                   wrTarget,
    output brTypeT                 wrType,
    output counterT                wrCount,
    output histT                   history
);

    // entry fields come straight from the resolved branch
    assign wrIndex  = resolvePc[`BPU_INDEX_BITS+1:2];
    assign wrTag    = resolvePc[`BPU_PC_BITS-1:`BPU_INDEX_BITS+2];
    assign wrTarget = resolveTarget;
    assign wrType   = resolveType;

    // counter next state
    always_comb begin
        if (!resolveHit) begin
            // fresh entry starts weak toward the outcome
            wrCount = resolveTaken ? wTaken : wNotTaken;
        end else begin
            unique case (resolveCount)
                sNotTaken: wrCount = resolveTaken ? wNotTaken : sNotTaken;
                wNotTaken: wrCount = resolveTaken ? wTaken    : sNotTaken;
                wTaken:    wrCount = resolveTaken ? sTaken    : wNotTaken;
                sTaken:    wrCount = resolveTaken ? sTaken    : wTaken;
                default:   wrCount = resolveTaken ? wTaken    : wNotTaken;
            endcase
        end
    end

    // write goes back to the bank the prediction was read from
    always_comb begin
        bankWe = '0;
        if (resolveValid) begin
            bankWe[resolveHistory] = 1'b1;
        end
    end

    // global history, newest outcome shifts in at bit 0
    always_ff @(posedge clk) begin
        if (!rstN) begin
            history <= '0;
        end else if (resolveValid && resolveType == BR_IMME) begin
            history <= {history[`BPU_HIST_BITS-2:0], resolveTaken};
        end
    end

endmodule

// File: hw/bhtBank.sv
/*
  One history bank of tagged predictor entries.
  Read is combinational; a write lands at the clock edge, so a read in the
  same cycle still sees the old entry.
  Only the valid bits are reset; entry contents are undefined until written.
*/
`timescale 1ns/1ps
`include "bpu_settings.svh"

module bhtBank import bpuPkg::*; (
    input  logic     clk,
    input  logic     rstN,
    input  logic     we,
    input  indexT    wrIndex,
    input  tagT      wrTag,
    input  addrT     wrTarget,
    input  brTypeT   wrType,
    input  counterT  wrCount,
    input  indexT    readIndex,
    output logic     rdValid,
    output tagT      rdTag,
    output addrT     rdTarget,
    output brTypeT   rdType,
    output counterT  rdCount
);

    // entry storage
    tagT     tagMem    [`BPU_ENTRIES];
    addrT    targetMem [`BPU_ENTRIES];
    brTypeT  typeMem   [`BPU_ENTRIES];
    counterT countMem  [`BPU_ENTRIES];

    // one valid bit per entry
    logic [`BPU_ENTRIES-1:0] validBits;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            validBits <= '0;
        end else if (we) begin
            validBits[wrIndex] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (we) begin
            tagMem[wrIndex]    <= wrTag;
            targetMem[wrIndex] <= wrTarget;
            typeMem[wrIndex]   <= wrType;
            countMem[wrIndex]  <= wrCount;
        end
    end

    // async read port
    assign rdValid  = validBits[readIndex];
    assign rdTag    = tagMem[readIndex];
    assign rdTarget = targetMem[readIndex];
    assign rdType   = typeMem[readIndex];
    assign rdCount  = countMem[readIndex];

endmodule

// File: hw/branchPredictor.sv
/*
  Fetch-side read path and stage register.
  Bank is chosen by the history at the moment fetchWr loads the register.
  Outputs are combinational from the register and hold while fetchWr is low.
  flush wins over fetchWr. Returns predict the stored target, no RAS.
  A miss reports count sNotTaken and type BR_NONE.
*/
`timescale 1ns/1ps
`include "bpu_settings.svh"

module branchPredictor import bpuPkg::*; (
    input  logic     clk,
    input  logic     rstN,
    input  addrT     fetchPc,
    input  logic     fetchWr,
    input  logic     flush,
    input  histT     history,
    input  logic     bankValid  [`BPU_BANKS],
    input  tagT      bankTag    [`BPU_BANKS],
    input  addrT     bankTarget [`BPU_BANKS],
    input  brTypeT   bankType   [`BPU_BANKS],
    input  counterT  bankCount  [`BPU_BANKS],
    output indexT    readIndex,
    output addrT     predTarget,
    output logic     predTaken,
    output logic     predValid,
    output logic     predHit,
    output brTypeT   predType,
    output counterT  predCount,
    output histT     predHistory
);

    // fetch address split
    tagT  fetchTag;
    addrT fetchPcPlus8;

    // stage register
    logic    stValid;
    logic    stEntryValid;
    tagT     stTag;
    tagT     stPcTag;
    addrT    stTarget;
    addrT    stPcPlus8;
    brTypeT  stType;
    counterT stCount;
    histT    stHist;

    assign readIndex    = fetchPc[`BPU_INDEX_BITS+1:2];
    assign fetchTag     = fetchPc[`BPU_PC_BITS-1:`BPU_INDEX_BITS+2];
    // fall-through skips the delay slot
    assign fetchPcPlus8 = fetchPc + `BPU_PC_BITS'(8);

    always_ff @(posedge clk) begin
        if (!rstN || flush) begin
            stValid      <= 1'b0;
            stEntryValid <= 1'b0;
            stTag        <= '0;
            stPcTag      <= '0;
            stTarget     <= '0;
            stPcPlus8    <= '0;
            stType       <= BR_NONE;
            stCount      <= sNotTaken;
            stHist       <= '0;
        end else if (fetchWr) begin
            // taken now means fetch is redirected, next slot is dead
            stValid      <= ~predTaken;
            stEntryValid <= bankValid[history];
            stTag        <= bankTag[history];
            stPcTag      <= fetchTag;
            stTarget     <= bankTarget[history];
            stPcPlus8    <= fetchPcPlus8;
            stType       <= bankType[history];
            stCount      <= bankCount[history];
            stHist       <= history;
        end
    end

    assign predHit     = stEntryValid && (stTag == stPcTag);
    assign predValid   = stValid;
    assign predHistory = stHist;
    assign predType    = predHit ? stType : BR_NONE;
    assign predCount   = predHit ? stCount : sNotTaken;

    // direction and target
    always_comb begin
        predTaken  = 1'b0;
        predTarget = stPcPlus8;
        if (predHit) begin
            unique case (stType)
                BR_CALL, BR_RETN: begin
                    predTaken  = 1'b1;
                    predTarget = stTarget;
                end
                BR_IMME: begin
                    // counter msb is the direction
                    if (stCount[1]) begin
                        predTaken  = 1'b1;
                        predTarget = stTarget;
                    end
                end
                default: begin
                    predTaken  = 1'b0;
                    predTarget = stPcPlus8;
                end
            endcase
        end
    end

endmodule

// File: hw/bpuTop.sv
/*
  Branch prediction unit top.
  Prediction appears the cycle after fetchWr; resolve writes at its edge.
  No back-pressure on either side; one fetch and one resolve per cycle.
*/
`timescale 1ns/1ps
`include "bpu_settings.svh"

module bpuTop import bpuPkg::*; (
    input  logic     clk,
    input  logic     rstN,
    input  addrT     fetchPc,
    input  logic     fetchWr,
    input  logic     flush,
    input  logic     resolveValid,
    input  addrT     resolvePc,
    input  addrT     resolveTarget,
    input  brTypeT   resolveType,
    input  logic     resolveTaken,
    input  logic     resolveHit,
    input  counterT  resolveCount,
    input  histT     resolveHistory,
    output addrT     predTarget,
    output logic     predTaken,
    output logic     predValid,
    output logic     predHit,
    output brTypeT   predType,
    output counterT  predCount,
    output histT     predHistory
);

    // shared write bus to the banks
    logic [`BPU_BANKS-1:0] bankWe;
    indexT   wrIndex;
    tagT     wrTag;
    addrT    wrTarget;
    brTypeT  wrType;
    counterT wrCount;
    histT    history;

    // read side
    indexT   readIndex;
    logic    bankValid  [`BPU_BANKS];
    tagT     bankTag    [`BPU_BANKS];
    addrT    bankTarget [`BPU_BANKS];
    brTypeT  bankType   [`BPU_BANKS];
    counterT bankCount  [`BPU_BANKS];

    bhtUpdate bhtUpdate_i (
        .clk(clk), .rstN(rstN),
        .resolveValid(resolveValid), .resolvePc(resolvePc),
        .resolveTarget(resolveTarget), .resolveType(resolveType),
        .resolveTaken(resolveTaken), .resolveHit(resolveHit),
        .resolveCount(resolveCount), .resolveHistory(resolveHistory),
        .bankWe(bankWe), .wrIndex(wrIndex), .wrTag(wrTag),
        .wrTarget(wrTarget), .wrType(wrType), .wrCount(wrCount),
        .history(history)
    );

    // one bank per history pattern
    for (genvar i = 0; i < `BPU_BANKS; i++) begin : genBank
        bhtBank bhtBank_i (
            .clk(clk), .rstN(rstN), .we(bankWe[i]),
            .wrIndex(wrIndex), .wrTag(wrTag), .wrTarget(wrTarget),
            .wrType(wrType), .wrCount(wrCount), .readIndex(readIndex),
            .rdValid(bankValid[i]), .rdTag(bankTag[i]), .rdTarget(bankTarget[i]),
            .rdType(bankType[i]), .rdCount(bankCount[i])
        );
    end

    branchPredictor branchPredictor_i (
        .clk(clk), .rstN(rstN), .fetchPc(fetchPc), .fetchWr(fetchWr),
        .flush(flush), .history(history),
        .bankValid(bankValid), .bankTag(bankTag), .bankTarget(bankTarget),
        .bankType(bankType), .bankCount(bankCount),
        .readIndex(readIndex), .predTarget(predTarget), .predTaken(predTaken),
        .predValid(predValid), .predHit(predHit), .predType(predType),
        .predCount(predCount), .predHistory(predHistory)
    );

endmodule

// File: verification/bpu_asserts.sv
/*
  Protocol checks bound onto bpuTop.
  All properties are held off while rstN is low.
  bankWe may be idle or one-hot, never more than one bank per resolve.
*/
`timescale 1ns/1ps
`include "bpu_settings.svh"

module bpuAsserts (
    input logic                  clk,
    input logic                  rstN,
    input logic [`BPU_BANKS-1:0] bankWe,
    input logic                  flush,
    input logic                  predValid,
    input logic                  predTaken,
    input logic                  predHit
);

    // a resolve writes one bank only
    weOneHot: assert property (@(posedge clk) disable iff (!rstN) $onehot0(bankWe))
        else $error("more than one bank write enable is high");

    // flushed slot is dead in the next cycle
    flushKills: assert property (@(posedge clk) disable iff (!rstN) flush |=> !predValid)
        else $error("predValid is high in the cycle after a flush");

    // only a stored entry can redirect fetch
    takenNeedsHit: assert property (@(posedge clk) disable iff (!rstN) predTaken |-> predHit)
        else $error("predTaken is high without predHit");

endmodule

bind bpuTop bpuAsserts bpuAsserts_i (
    .clk(clk),
    .rstN(rstN),
    .bankWe(bankWe),
    .flush(flush),
    .predValid(predValid),
    .predTaken(predTaken),
    .predHit(predHit)
);

// File: verification/bpuTb.sv
/*
  Table-driven testbench for bpuTop.
  Expected values come from a model of the banks, the history and the stage
  register, which runs while the table is built and before it is applied.
  Each row takes one clock. Inputs change on the falling edge, and outputs
  are sampled on the next falling edge.
*/
`timescale 1ns/1ps
`include "bpu_settings.svh"

module bpuTb import bpuPkg::*; ();

    localparam int FETCH   = 0;
    localparam int RESOLVE = 1;
    localparam int FLUSH   = 2;

    // expected prediction outputs
    typedef struct {
        logic    eValid;
        logic    eTaken;
        logic    eHit;
        addrT    eTarget;
        brTypeT  eType;
        counterT eCount;
        histT    eHist;
        logic    eFull;
    } expT;

    typedef struct {
        int      kind;
        addrT    pc;
        addrT    target;
        brTypeT  btype;
        logic    taken;
        histT    rHist;
        logic    rHit;
        counterT rCount;
        expT     exp;
    } rowT;

    logic    clk, rstN, fetchWr, flush, resolveValid, resolveTaken, resolveHit;
    addrT    fetchPc, resolvePc, resolveTarget, predTarget;
    brTypeT  resolveType, predType;
    counterT resolveCount, predCount;
    histT    resolveHistory, predHistory;
    logic    predTaken, predValid, predHit;

    // model of the tables, the history and the outputs held by the stage register
    logic    mValid  [`BPU_BANKS][`BPU_ENTRIES];
    tagT     mTag    [`BPU_BANKS][`BPU_ENTRIES];
    addrT    mTarget [`BPU_BANKS][`BPU_ENTRIES];
    brTypeT  mType   [`BPU_BANKS][`BPU_ENTRIES];
    counterT mCount  [`BPU_BANKS][`BPU_ENTRIES];
    histT    mHist;
    expT     held;

    rowT rows[$];
    int  seed = 97477;
    int  errors = 0;
    int  rowErrors = 0;
    int  passed = 0;
    int  failed = 0;
    int  cycles = 0;
    int  cycleLimit = 0;

    bpuTop bpuTop_i (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // run limit from the table length
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycleLimit > 0 && cycles >= cycleLimit) begin
            $display("timeout after %0d cycles, the table did not finish", cycles);
            $display("Testbench failed");
            $finish;
        end
    end

    // allocate weak, else step toward the outcome and stop at the ends
    function automatic counterT nextCount(logic hit, counterT c, logic taken);
        int v;
        v = int'(c);
        if (!hit) begin
            return taken ? wTaken : wNotTaken;
        end
        if (taken && v < 3) begin
            v = v + 1;
        end else if (!taken && v > 0) begin
            v = v - 1;
        end
        return counterT'(v[1:0]);
    endfunction

    task automatic addRow(input int kind, input addrT pc, input addrT target,
                          input brTypeT btype, input logic taken, input histT rHist);
        rowT   r;
        indexT idx;
        tagT   tag;
        histT  b;
        logic  hit;
        idx = pc[`BPU_INDEX_BITS+1:2];
        tag = pc[`BPU_PC_BITS-1:`BPU_INDEX_BITS+2];
        r.kind = kind;
        r.pc = pc;
        r.target = target;
        r.btype = btype;
        r.taken = taken;
        r.rHist = rHist;
        r.rHit = 1'b0;
        r.rCount = sNotTaken;
        if (kind == RESOLVE) begin
            // hit and count as the predictor would have reported them
            b = rHist;
            r.rHit = mValid[b][idx] && (mTag[b][idx] == tag);
            r.rCount = r.rHit ? mCount[b][idx] : sNotTaken;
            mValid[b][idx] = 1'b1;
            mTag[b][idx] = tag;
            mTarget[b][idx] = target;
            mType[b][idx] = btype;
            mCount[b][idx] = nextCount(r.rHit, r.rCount, taken);
            if (btype == BR_IMME) begin
                mHist = {mHist[0], taken};
            end
        end else if (kind == FETCH) begin
            b = mHist;
            hit = mValid[b][idx] && (mTag[b][idx] == tag);
            // slot after a taken prediction is dead
            held.eValid = !held.eTaken;
            held.eHit = hit;
            held.eType = hit ? mType[b][idx] : BR_NONE;
            held.eCount = hit ? mCount[b][idx] : sNotTaken;
            held.eTaken = hit && (held.eType == BR_CALL || held.eType == BR_RETN ||
                          (held.eType == BR_IMME &&
                           (held.eCount == wTaken || held.eCount == sTaken)));
            held.eTarget = held.eTaken ? mTarget[b][idx] : pc + 32'd8;
            held.eHist = mHist;
            held.eFull = 1'b1;
        end else begin
            held.eValid = 1'b0;
            held.eTaken = 1'b0;
            held.eHit = 1'b0;
            held.eType = BR_NONE;
            held.eCount = sNotTaken;
            held.eFull = 1'b0;
        end
        r.exp = held;
        rows.push_back(r);
    endtask

    // random conditional branch written to bank 0, used to steer the history
    task automatic addFiller(input logic taken);
        addrT pc;
        addrT target;
        pc = $random(seed);
        target = $random(seed);
        addRow(RESOLVE, pc & 32'hFFFF_FFFC, target & 32'hFFFF_FFFC, BR_IMME, taken, 2'b00);
    endtask

    task automatic buildTable();
        addrT pcA;
        addrT pcC;
        addrT pcD;
        pcA = 32'h0000_1000;
        pcC = 32'h0000_4080;
        pcD = 32'h0000_5104;
        for (int b = 0; b < `BPU_BANKS; b++) begin
            for (int i = 0; i < `BPU_ENTRIES; i++) begin
                mValid[b][i] = 1'b0;
            end
        end
        mHist = 2'b00;
        held = '{1'b0, 1'b0, 1'b0, 32'd0, BR_NONE, sNotTaken, 2'b00, 1'b0};
        // cold miss, then allocate and hit under history 01
        addRow(FETCH, pcA, 32'd0, BR_NONE, 1'b0, 2'b00);
        addRow(RESOLVE, pcA, 32'h0000_3000, BR_IMME, 1'b1, 2'b01);
        addRow(FETCH, pcA, 32'd0, BR_NONE, 1'b0, 2'b00);
        addRow(FETCH, pcA, 32'd0, BR_NONE, 1'b0, 2'b00);
        // saturate taken in bank 3
        repeat (3) addRow(RESOLVE, pcA, 32'h0000_3000, BR_IMME, 1'b1, 2'b11);
        addRow(FETCH, pcA, 32'd0, BR_NONE, 1'b0, 2'b00);
        // walk down to sNotTaken, fillers bring the history back to 11
        repeat (4) begin
            addRow(RESOLVE, pcA, 32'h0000_3000, BR_IMME, 1'b0, 2'b11);
            addFiller(1'b1);
            addFiller(1'b1);
            addRow(FETCH, pcA, 32'd0, BR_NONE, 1'b0, 2'b00);
        end
        // call with a not-taken counter in bank 1, then read under 01 and 10
        addRow(RESOLVE, pcC, 32'h0000_6000, BR_CALL, 1'b0, 2'b01);
        addFiller(1'b0);
        addFiller(1'b1);
        addRow(FETCH, pcC, 32'd0, BR_NONE, 1'b0, 2'b00);
        addFiller(1'b0);
        addRow(FETCH, pcC, 32'd0, BR_NONE, 1'b0, 2'b00);
        // return in bank 2
        addRow(RESOLVE, pcD, 32'h0000_7000, BR_RETN, 1'b0, 2'b10);
        addRow(FETCH, pcD, 32'd0, BR_NONE, 1'b0, 2'b00);
        // flush beats fetchWr
        addRow(FLUSH, pcA, 32'd0, BR_NONE, 1'b0, 2'b00);
        addRow(FETCH, pcD, 32'd0, BR_NONE, 1'b0, 2'b00);
        addRow(FETCH, pcA, 32'd0, BR_NONE, 1'b0, 2'b00);
        // outputs hold through a resolve
        addRow(RESOLVE, pcA, 32'h0000_3000, BR_IMME, 1'b1, 2'b10);
        cycleLimit = rows.size() * 4 + 16;
    endtask

    task automatic driveRow(input rowT r);
        fetchWr = (r.kind != RESOLVE);
        flush = (r.kind == FLUSH);
        fetchPc = r.pc;
        resolveValid = (r.kind == RESOLVE);
        resolvePc = r.pc;
        resolveTarget = r.target;
        resolveType = r.btype;
        resolveTaken = r.taken;
        resolveHit = r.rHit;
        resolveCount = r.rCount;
        resolveHistory = r.rHist;
    endtask

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERROR at %0t: %s is %h, expected %h", $time, name, got, exp);
            errors++;
            rowErrors++;
        end
    endtask

    task automatic checkOutputs(input expT e);
        checkValue("predValid", 32'(predValid), 32'(e.eValid));
        checkValue("predTaken", 32'(predTaken), 32'(e.eTaken));
        checkValue("predHit", 32'(predHit), 32'(e.eHit));
        checkValue("predType", 32'(predType), 32'(e.eType));
        checkValue("predCount", 32'(predCount), 32'(e.eCount));
        // target and history are only defined once a fetch was loaded
        if (e.eFull) begin
            checkValue("predTarget", predTarget, e.eTarget);
            checkValue("predHistory", 32'(predHistory), 32'(e.eHist));
        end
    endtask

    task automatic reportTest(input string label);
        if (rowErrors == 0) begin
            passed++;
            $display("%s: ok", label);
        end else begin
            failed++;
            $display("%s: %0d mismatches", label, rowErrors);
        end
        rowErrors = 0;
    endtask

    function automatic string kindName(int kind);
        if (kind == FETCH) begin
            return "fetch";
        end else if (kind == RESOLVE) begin
            return "resolve";
        end
        return "flush";
    endfunction

    initial begin
        rstN = 1'b0;
        fetchWr = 1'b0;
        flush = 1'b0;
        fetchPc = '0;
        resolveValid = 1'b0;
        resolvePc = '0;
        resolveTarget = '0;
        resolveType = BR_NONE;
        resolveTaken = 1'b0;
        resolveHit = 1'b0;
        resolveCount = sNotTaken;
        resolveHistory = '0;
        buildTable();
        repeat (16) @(negedge clk);
        rstN = 1'b1;
        // reset state
        checkValue("predValid", 32'(predValid), 32'd0);
        checkValue("predTaken", 32'(predTaken), 32'd0);
        checkValue("predHit", 32'(predHit), 32'd0);
        reportTest("reset");
        foreach (rows[i]) begin
            driveRow(rows[i]);
            @(negedge clk);
            checkOutputs(rows[i].exp);
            reportTest($sformatf("row %0d %s pc=%h", i, kindName(rows[i].kind), rows[i].pc));
        end
        fetchWr = 1'b0;
        flush = 1'b0;
        resolveValid = 1'b0;
        @(negedge clk);
        $display("tests %0d, passed %0d, failed %0d, errors %0d",
                 passed + failed, passed, failed, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: project.f
+incdir+hw
hw/bpuPkg.sv
hw/bhtUpdate.sv
hw/bhtBank.sv
hw/branchPredictor.sv
hw/bpuTop.sv
verification/bpu_asserts.sv
verification/bpuTb.sv

// File: run.sh
#!/bin/bash
# Build and run the branch predictor testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f project.f --top-module bpuTb -Mdir obj_dir

output=$(./obj_dir/VbpuTb 2>&1) || true
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx "Testbench passed"; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi
